// File: src/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// First fetch address after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Architectural register count
`define MIPS_NUM_REGS 32

// Result register shown on register_v0
`define MIPS_REG_V0 5'd2

// Link register written by jal
`define MIPS_REG_RA 5'd31

`endif

// File: src/mips_pkg.sv
package mips_pkg;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,	// Decoded further by funct
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_SLTI  = 6'h0A,
		OP_SLTIU = 6'h0B,
		OP_ANDI  = 6'h0C,
		OP_ORI   = 6'h0D,
		OP_XORI  = 6'h0E,
		OP_LUI   = 6'h0F,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2B
	} opcode_e;

	typedef enum logic [5:0] {
		F_SLL  = 6'h00,
		F_SRL  = 6'h02,
		F_SRA  = 6'h03,
		F_JR   = 6'h08,
		F_ADDU = 6'h21,
		F_SUBU = 6'h23,
		F_AND  = 6'h24,
		F_OR   = 6'h25,
		F_XOR  = 6'h26,
		F_SLT  = 6'h2A,
		F_SLTU = 6'h2B
	} funct_e;

	typedef enum logic [4:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_t;

	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_view_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_view_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] target;	// Word index inside the 256 MB region
	} j_view_t;

	// Same 32-bit word, three field layouts
	typedef union packed {
		r_view_t r;
		i_view_t i;
		j_view_t j;
	} instr_t;

	typedef struct packed {
		logic    reg_write;
		logic    reg_dst_rd;	// Write rd instead of rt
		logic    link;		// Write PC+4 to $ra
		logic    alu_src_imm;
		logic    imm_zero_ext;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    branch_eq;
		logic    branch_ne;
		logic    jump;
		logic    jump_reg;
		alu_op_t alu_op;
		logic    shift_imm;	// Shift amount from shamt field
	} ctrl_t;

endpackage

// File: src/mips_control.sv
`timescale 1ns/1ps

module mips_control import mips_pkg::*; (
	input  instr_t instr,
	output ctrl_t  ctrl
);

	always_comb begin
		ctrl = '0;	// Unknown codes write nothing
		case (instr.r.opcode)
			OP_RTYPE: begin
				ctrl.reg_write = 1'b1;	// Most R-type write rd
				ctrl.reg_dst_rd = 1'b1;
				case (instr.r.funct)
					F_ADDU: ctrl.alu_op = ALU_ADD;
					F_SUBU: ctrl.alu_op = ALU_SUB;
					F_AND:  ctrl.alu_op = ALU_AND;
					F_OR:   ctrl.alu_op = ALU_OR;
					F_XOR:  ctrl.alu_op = ALU_XOR;
					F_SLT:  ctrl.alu_op = ALU_SLT;
					F_SLTU: ctrl.alu_op = ALU_SLTU;
					F_SLL: begin
						ctrl.alu_op = ALU_SLL;
						ctrl.shift_imm = 1'b1;
					end
					F_SRL: begin
						ctrl.alu_op = ALU_SRL;
						ctrl.shift_imm = 1'b1;
					end
					F_SRA: begin
						ctrl.alu_op = ALU_SRA;
						ctrl.shift_imm = 1'b1;
					end
					F_JR: begin
						ctrl.reg_write = 1'b0;	// No destination
						ctrl.reg_dst_rd = 1'b0;
						ctrl.jump_reg = 1'b1;
					end
					default: ctrl = '0;
				endcase
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;	// Sign-extended immediate
				ctrl.alu_op = (instr.r.opcode == OP_ADDIU) ? ALU_ADD :
					(instr.r.opcode == OP_SLTI) ? ALU_SLT : ALU_SLTU;
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.imm_zero_ext = 1'b1;	// Logic ops take zero extension
				ctrl.alu_op = (instr.r.opcode == OP_ANDI) ? ALU_AND :
					(instr.r.opcode == OP_ORI) ? ALU_OR :
					(instr.r.opcode == OP_XORI) ? ALU_XOR : ALU_LUI;
			end
			OP_LW: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;	// Base plus offset
				ctrl.mem_read = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_op = ALU_ADD;
			end
			OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.alu_op = ALU_ADD;
			end
			OP_BEQ: begin
				ctrl.branch_eq = 1'b1;
				ctrl.alu_op = ALU_SUB;	// Zero flag compares rs and rt
			end
			OP_BNE: begin
				ctrl.branch_ne = 1'b1;
				ctrl.alu_op = ALU_SUB;
			end
			OP_J: ctrl.jump = 1'b1;
			OP_JAL: begin
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;	// Return address into $ra
				ctrl.reg_write = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

endmodule

// File: src/mips_regfile.sv
`timescale 1ns/1ps

`include "mips_params.svh"

module mips_regfile (
	input  logic        clk,
	input  logic [4:0]  ra1,
	input  logic [4:0]  ra2,
	input  logic [4:0]  wa,
	input  logic        we,
	input  logic [31:0] wd,
	output logic [31:0] rd1,
	output logic [31:0] rd2
);

	logic [31:0] regs [`MIPS_NUM_REGS];	// Contents not cleared by reset

	// Single write port on the rising edge
	always_ff @(posedge clk) begin
		if (we && (wa != 5'd0)) begin	// $zero never stored
			regs[wa] <= wd;
		end
	end

	assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];	// $zero hardwired
	assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

// File: src/mips_alu.sv
`timescale 1ns/1ps

module mips_alu import mips_pkg::*; (
	input  alu_op_t     op,
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [4:0]  shamt,
	output logic [31:0] y,
	output logic        zero
);

	logic        lt_signed;	// Signed compare result
	logic        lt_unsigned;
	logic [31:0] sra_res;

	assign lt_signed = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;
	assign sra_res = $unsigned($signed(b) >>> shamt);	// Sign fill from bit 31

	always_comb begin
		case (op)
			ALU_ADD:  y = a + b;	// Wraps, no overflow trap
			ALU_SUB:  y = a - b;
			ALU_AND:  y = a & b;
			ALU_OR:   y = a | b;
			ALU_XOR:  y = a ^ b;
			ALU_SLT:  y = {31'd0, lt_signed};
			ALU_SLTU: y = {31'd0, lt_unsigned};
			ALU_SLL:  y = b << shamt;	// Shifts act on rt
			ALU_SRL:  y = b >> shamt;
			ALU_SRA:  y = sra_res;
			ALU_LUI:  y = {b[15:0], 16'h0000};	// Immediate to upper half
			default:  y = 32'd0;
		endcase
	end

	assign zero = (y == 32'd0);	// Equality test for branches

endmodule

// File: src/mips_datapath.sv
`timescale 1ns/1ps

`include "mips_params.svh"

module mips_datapath import mips_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	input  instr_t      instr,
	input  ctrl_t       ctrl,
	input  logic [31:0] data_readdata,
	output logic [31:0] pc,
	output logic [31:0] data_address,
	output logic [31:0] data_writedata,
	output logic        data_read,
	output logic        data_write,
	output logic        active,
	output logic [31:0] register_v0
);

	logic [31:0] pc_plus4;
	logic [31:0] branch_target;
	logic [31:0] jump_target;
	logic [31:0] pc_next;
	logic [31:0] imm_ext;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic [31:0] alu_b;
	logic [31:0] alu_y;
	logic [31:0] wb_data;
	logic [4:0]  wa;
	logic [4:0]  alu_shamt;
	logic        alu_zero;
	logic        branch_taken;
	logic        commit;	// This edge retires the instruction
	logic        reg_we;
	logic        halt;

	assign commit = clk_enable & active & ~reset;	// Nothing retires in reset
	assign reg_we = ctrl.reg_write & commit;

	// Immediate and ALU operand selection
	assign imm_ext = ctrl.imm_zero_ext ? {16'd0, instr.i.imm} :
		{{16{instr.i.imm[15]}}, instr.i.imm};
	assign alu_b = ctrl.alu_src_imm ? imm_ext : rt_val;
	assign alu_shamt = ctrl.shift_imm ? instr.r.shamt : 5'd0;

	// Destination register: $ra, rd or rt
	assign wa = ctrl.link ? `MIPS_REG_RA :
		ctrl.reg_dst_rd ? instr.r.rd : instr.i.rt;

	// Writeback value
	assign wb_data = ctrl.link ? pc_plus4 :
		ctrl.mem_to_reg ? data_readdata : alu_y;

	mips_regfile regfile0 (
		.clk (clk),
		.ra1 (instr.i.rs),
		.ra2 (instr.i.rt),
		.wa  (wa),
		.we  (reg_we),
		.wd  (wb_data),
		.rd1 (rs_val),
		.rd2 (rt_val)
	);

	mips_alu alu0 (
		.op    (ctrl.alu_op),
		.a     (rs_val),
		.b     (alu_b),
		.shamt (alu_shamt),
		.y     (alu_y),
		.zero  (alu_zero)
	);

	// Next PC without delay slot
	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};	// Word offset
	assign jump_target = {pc_plus4[31:28], instr.j.target, 2'b00};
	assign branch_taken = (ctrl.branch_eq & alu_zero) | (ctrl.branch_ne & ~alu_zero);
	assign pc_next = ctrl.jump_reg ? rs_val :
		ctrl.jump ? jump_target :
		branch_taken ? branch_target : pc_plus4;

	assign halt = ctrl.jump_reg & (rs_val == 32'd0);	// jr to address zero

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= `MIPS_RESET_VECTOR;
			active <= 1'b1;
		end else if (commit) begin
			pc <= pc_next;	// Frozen once active drops
			if (halt) begin
				active <= 1'b0;
			end
		end
	end

	// Shadow copy of $v0 since the file has only two read ports
	always_ff @(posedge clk) begin
		if (reg_we && (wa == `MIPS_REG_V0)) begin
			register_v0 <= wb_data;
		end
	end

	// Data memory port
	assign data_address = alu_y;
	assign data_writedata = rt_val;
	assign data_read = ctrl.mem_read & active & ~reset;	// Quiet during reset
	assign data_write = ctrl.mem_write & commit;	// No store while stalled

endmodule

// File: src/mips_cpu_harvard.sv
`timescale 1ns/1ps

module mips_cpu_harvard import mips_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        clk_enable,
	input  logic [31:0] instr_readdata,
	input  logic [31:0] data_readdata,
	output logic        active,
	output logic [31:0] register_v0,
	output logic [31:0] instr_address,
	output logic [31:0] data_address,
	output logic        data_read,
	output logic        data_write,
	output logic [31:0] data_writedata
);

	instr_t instr;	// Fetched word seen through the union
	ctrl_t  ctrl;

	assign instr = instr_t'(instr_readdata);

	mips_control control0 (
		.instr (instr),
		.ctrl  (ctrl)
	);

	mips_datapath datapath0 (
		.clk            (clk),
		.reset          (reset),
		.clk_enable     (clk_enable),
		.instr          (instr),
		.ctrl           (ctrl),
		.data_readdata  (data_readdata),
		.pc             (instr_address),	// Fetch address is the PC
		.data_address   (data_address),
		.data_writedata (data_writedata),
		.data_read      (data_read),
		.data_write     (data_write),
		.active         (active),
		.register_v0    (register_v0)
	);

endmodule

// File: verification/mips_chk.sv
`timescale 1ns/1ps

module mips_chk (
	input logic        clk,
	input logic        reset,
	input logic        clk_enable,
	input logic        active,
	input logic        data_read,
	input logic        data_write,
	input logic [31:0] data_address,
	input logic [31:0] instr_address
);

	logic err_excl = 1'b0;	// One flag per property
	logic err_align = 1'b0;
	logic err_stall = 1'b0;
	logic err_halt = 1'b0;
	logic any_error;

	assign any_error = err_excl | err_align | err_stall | err_halt;	// Seen by the testbench

	assert property (@(posedge clk) disable iff (reset) !(data_read && data_write))
	else begin
		err_excl = 1'b1;
		$error("data_read and data_write high together");
	end

	// Word accesses only
	assert property (@(posedge clk) disable iff (reset)
		(data_read || data_write) |-> (data_address[1:0] == 2'b00))
	else begin
		err_align = 1'b1;
		$error("data_address not word aligned");
	end

	assert property (@(posedge clk) disable iff (reset) !clk_enable |=> $stable(instr_address))
	else begin
		err_stall = 1'b1;
		$error("PC moved on a stalled edge");
	end

	assert property (@(posedge clk) disable iff (reset) !active |-> !data_write)
	else begin
		err_halt = 1'b1;
		$error("store issued after halt");
	end

endmodule

bind mips_cpu_harvard mips_chk chk0 (
	.clk           (clk),
	.reset         (reset),
	.clk_enable    (clk_enable),
	.active        (active),
	.data_read     (data_read),
	.data_write    (data_write),
	.data_address  (data_address),
	.instr_address (instr_address)
);

// File: verification/mips_tb.sv
`timescale 1ns/1ps

`include "mips_params.svh"

module mips_tb import mips_pkg::*; ();

	logic        clk = 1'b0;
	logic        reset;
	logic        clk_enable;
	logic        active;
	logic        data_read;
	logic        data_write;
	logic [31:0] instr_readdata, data_readdata, register_v0;
	logic [31:0] instr_address, data_address, data_writedata;

	logic [31:0] rom [64];	// Program from the reset vector
	logic [31:0] dmem [64];
	logic [31:0] m_dmem [64];	// Model memory
	logic [31:0] m_regs [32];
	logic [31:0] m_pc;
	logic        m_active;
	integer      seed = 95;
	int          prog_len = 0;
	int          store_off = 0;	// Next result slot
	int          cyc;

	always #10 clk = ~clk;	// 20 ns period

	mips_cpu_harvard dut0 (.*);

	function automatic logic [31:0] rom_word(input logic [31:0] addr);
		logic [31:0] idx;
		idx = (addr - `MIPS_RESET_VECTOR) >> 2;
		return (idx < 32'd64) ? rom[idx[5:0]] : 32'd0;	// Nop outside the program
	endfunction

	always_comb begin
		instr_readdata = rom_word(instr_address);	// Combinational fetch
	end

	assign data_readdata = dmem[data_address[7:2]];

	always @(posedge clk) begin
		if (data_write && clk_enable) begin
			dmem[data_address[7:2]] <= data_writedata;
		end
	end

	always @(posedge clk) begin
		if (!reset) begin
			clk_enable <= ($random(seed) & 32'd3) != 32'd0;	// Stall about one edge in four
		end
	end

	function automatic logic [31:0] enc_r(input funct_e f, input int rd, rs, rt, sh);
		return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], sh[4:0], f};
	endfunction

	function automatic logic [31:0] enc_i(input opcode_e op, input int rt, rs, imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] enc_j(input opcode_e op, input int word_idx);
		logic [31:0] addr;
		addr = `MIPS_RESET_VECTOR + word_idx * 4;
		return {op, addr[27:2]};	// Same 256 MB region
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] got, exp);
		assert (got === exp) else abort_run($sformatf("mismatch at %0t: %s is %h, expected %h",
			$time, name, got, exp));
	endtask

	task automatic emit(input logic [31:0] w);
		rom[prog_len[5:0]] = w;
		prog_len++;
	endtask

	// ALU result goes straight to memory for checking
	task automatic emit_stored(input logic [31:0] w);
		logic [4:0] dst;
		dst = (w[31:26] == 6'd0) ? w[15:11] : w[20:16];	// rd for R-type, rt otherwise
		emit(w);
		emit(enc_i(OP_SW, int'(dst), 0, store_off));
		store_off += 4;
	endtask

	// ISA-level step of one instruction
	task automatic step_model;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] ea;
		logic [31:0] res;
		logic [31:0] nxt;
		logic [4:0]  dst;
		logic        wr;
		w = rom_word(m_pc);
		a = m_regs[w[25:21]];
		b = m_regs[w[20:16]];
		simm = {{16{w[15]}}, w[15:0]};
		ea = a + simm;
		nxt = m_pc + 32'd4;	// No delay slot
		dst = w[20:16];
		wr = 1'b1;
		res = 32'd0;
		case (w[31:26])
			OP_RTYPE: begin
				dst = w[15:11];
				case (w[5:0])
					F_ADDU: res = a + b;
					F_SUBU: res = a - b;
					F_AND:  res = a & b;
					F_OR:   res = a | b;
					F_XOR:  res = a ^ b;
					F_SLT:  res = {31'd0, $signed(a) < $signed(b)};
					F_SLTU: res = {31'd0, a < b};
					F_SLL:  res = b << w[10:6];
					F_SRL:  res = b >> w[10:6];
					F_SRA:  res = $signed(b) >>> w[10:6];
					F_JR: begin
						wr = 1'b0;
						nxt = a;
						m_active = (a != 32'd0);	// jr to zero halts
					end
					default: wr = 1'b0;
				endcase
			end
			OP_ADDIU: res = ea;
			OP_SLTI:  res = {31'd0, $signed(a) < $signed(simm)};
			OP_SLTIU: res = {31'd0, a < simm};
			OP_ANDI:  res = a & {16'd0, w[15:0]};
			OP_ORI:   res = a | {16'd0, w[15:0]};
			OP_XORI:  res = a ^ {16'd0, w[15:0]};
			OP_LUI:   res = {w[15:0], 16'd0};
			OP_LW:    res = m_dmem[ea[7:2]];
			OP_SW: begin
				wr = 1'b0;
				check_word("data_address", data_address, ea);
				check_word("data_writedata", data_writedata, b);
				m_dmem[ea[7:2]] = b;
			end
			OP_BEQ, OP_BNE: begin
				wr = 1'b0;
				if ((a == b) == (w[31:26] == OP_BEQ)) begin
					nxt = nxt + {simm[29:0], 2'b00};
				end
			end
			OP_J, OP_JAL: begin
				dst = `MIPS_REG_RA;
				res = nxt;	// Link is PC+4
				wr = (w[31:26] == OP_JAL);
				nxt = {nxt[31:28], w[25:0], 2'b00};
			end
			default: wr = 1'b0;
		endcase
		check_word("data_write", {31'd0, data_write}, {31'd0, w[31:26] == OP_SW});
		check_word("data_read", {31'd0, data_read}, {31'd0, w[31:26] == OP_LW});
		if (wr && dst != 5'd0) begin
			m_regs[dst] = res;
		end
		m_pc = nxt;
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk) begin
		if (dut0.chk0.any_error) begin
			abort_run("an assertion in mips_chk failed");
		end else if (reset) begin
			check_word("instr_address", instr_address, `MIPS_RESET_VECTOR);
			check_word("active", {31'd0, active}, 32'd1);
			check_word("data_write", {31'd0, data_write}, 32'd0);
		end else begin
			check_word("instr_address", instr_address, m_pc);
			check_word("active", {31'd0, active}, {31'd0, m_active});
			if (clk_enable && m_active) begin
				step_model;
			end else begin
				check_word("data_write", {31'd0, data_write}, 32'd0);	// Stalled or halted
			end
		end
	end

	initial begin
		reset = 1'b1;
		clk_enable = 1'b1;
		m_pc = `MIPS_RESET_VECTOR;
		m_active = 1'b1;
		m_regs[0] = 32'd0;
		emit(enc_i(OP_SW, 0, 0, 208));	// Store at the reset vector
		emit_stored(enc_i(OP_LUI, 8, 0, 'h8000));	// 0x80000000
		emit_stored(enc_i(OP_ADDIU, 9, 0, -5));
		emit_stored(enc_i(OP_ORI, 10, 0, 'h1234));
		emit_stored(enc_i(OP_ADDIU, 11, 8, -1));	// Wraps to 0x7FFFFFFF
		emit_stored(enc_r(F_ADDU, 12, 11, 11, 0));	// Signed overflow
		emit_stored(enc_r(F_SUBU, 13, 8, 10, 0));
		emit_stored(enc_r(F_AND, 14, 9, 10, 0));
		emit_stored(enc_r(F_OR, 15, 9, 10, 0));
		emit_stored(enc_r(F_XOR, 16, 9, 10, 0));
		emit_stored(enc_r(F_SLT, 17, 9, 10, 0));	// Negative below positive
		emit_stored(enc_r(F_SLTU, 18, 9, 10, 0));
		emit_stored(enc_r(F_SLL, 19, 0, 9, 4));
		emit_stored(enc_r(F_SRL, 20, 0, 9, 4));
		emit_stored(enc_r(F_SRA, 21, 0, 8, 3));	// Sign fill
		emit_stored(enc_i(OP_ANDI, 22, 9, 'hF0F0));
		emit_stored(enc_i(OP_XORI, 23, 9, 'hFFFF));
		emit_stored(enc_i(OP_SLTI, 24, 9, -4));
		emit_stored(enc_i(OP_SLTIU, 25, 9, -4));
		emit(enc_i(OP_SW, 10, 0, 200));
		emit(enc_i(OP_LW, 3, 0, 200));	// Reads back the store
		emit(enc_r(F_ADDU, 2, 3, 12, 0));	// Loaded value into $v0
		emit(enc_i(OP_BEQ, 9, 9, 1));	// Taken
		emit(enc_i(OP_ADDIU, 2, 0, 0));
		emit(enc_i(OP_BNE, 9, 9, 1));	// Not taken
		emit(enc_i(OP_BEQ, 10, 9, 1));	// Not taken
		emit(enc_i(OP_BNE, 10, 9, 1));	// Taken
		emit(enc_i(OP_ADDIU, 2, 0, 0));
		emit(enc_j(OP_JAL, prog_len + 3));
		emit(enc_i(OP_SW, 31, 0, 204));	// Link value to memory
		emit(enc_j(OP_J, prog_len + 2));
		emit(enc_r(F_JR, 0, 31, 0, 0));	// Subroutine return
		emit(enc_r(F_JR, 0, 0, 0, 0));	// Halt
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		for (cyc = 0; cyc < 2000 && active; cyc++) begin
			@(negedge clk);
		end
		if (active) begin
			abort_run("timeout: active never fell after the final jr");
		end else begin
			@(negedge clk);
			check_word("register_v0", register_v0, m_regs[`MIPS_REG_V0]);
			if (dut0.chk0.any_error) begin
				abort_run("an assertion in mips_chk failed");
			end else begin
				$display("PASS: all tests");
				$finish;
			end
		end
	end

endmodule

// File: all.f
+incdir+src
src/mips_pkg.sv
src/mips_control.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_datapath.sv
src/mips_cpu_harvard.sv
verification/mips_chk.sv
verification/mips_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= mips_tb
FILELIST   ?= all.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall
SIM_ARGS   ?= +verilator+error+limit+10
PASS_MSG   ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
